// File: pa_unit.f
+incdir+.
pa_pkg.sv
pa_alu_slice.sv
pa_arith.sv
pa_regs.sv
pa_bus.sv
pa_unit.sv
tb_pa_unit.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_pa_unit
FILELIST  ?= pa_unit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
FAIL_MSG  ?= Some tests failed
PASS_MSG  ?= All tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "FAIL, no result"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb_pa_tasks.svh
`ifndef TB_PA_TASKS_SVH
`define TB_PA_TASKS_SVH

// wait for a rising edge, then move 2 ns past it
// polls run half a ns off the clock edges
task automatic tick();
	int guard;
	guard = 0;
	#0.5;
	while (clk !== 1'b0 && guard < 60) begin
		#1;
		guard++;
	end
	while (clk !== 1'b1 && guard < 60) begin
		#1;
		guard++;
	end
	if (guard >= 60) begin
		err_count++;
		$display("no rising clock edge seen within the wait limit");
	end
	#1.5;
endtask

task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
	check_count++;
	if (got !== exp) begin
		err_count++;
		$display("ERR %s: got %h, expected %h", name, got, exp);
	end
endtask

task automatic set_idle();
	ir = '0;
	ki = '0;
	kl = '0;
	rdt = '0;
	l = '0;
	alu_ctrl = '0;
	reg_ctrl = '0;
	bus_ctrl = '0;
	bus_ctrl.a_sel = 2'd3;
endtask

task automatic load_w(input logic [15:0] v, input logic ac_en, input logic ar_en,
	input logic ic_en);
	kl = v;
	bus_ctrl.w_sel = W_KL;
	reg_ctrl.w_ac = ac_en;
	reg_ctrl.w_ar = ar_en;
	reg_ctrl.w_ic = ic_en;
	tick();
	reg_ctrl = '0;
endtask

// AR through A and W, IC likewise, both through dad_n
task automatic read_ar_ic(input logic [15:0] ar_e, input logic [15:0] ic_e);
	bus_ctrl.w_sel = W_A;
	bus_ctrl.a_sel = 2'd2;
	bus_ctrl.ar_ad = 1'b1;
	bus_ctrl.ic_ad = 1'b0;
	#5;
	check_val("w(ar)", w, ar_e);
	check_val("dad_n(ar)", dad_n, ~ar_e);
	check_val("arz", 16'(arz), 16'(|ar_e[15:8]));
	bus_ctrl.a_sel = 2'd1;
	bus_ctrl.ar_ad = 1'b0;
	bus_ctrl.ic_ad = 1'b1;
	#5;
	check_val("w(ic)", w, ic_e);
	check_val("dad_n(ic)", dad_n, ~ic_e);
	bus_ctrl.ic_ad = 1'b0;
	bus_ctrl.a_sel = 2'd3;
endtask

task automatic test_reset();
	bus_ctrl.w_sel = W_AC;
	#5;
	check_val("w(ac)", w, 16'h0);
	check_val("ddt_n", ddt_n, 16'hffff);
	bus_ctrl.w_sel = W_AT;
	#5;
	check_val("w(at)", w, 16'h0);
	check_val("wzi", 16'(wzi), 16'h0);
	read_ar_ic(16'h0, `PA_IC_RST);
endtask

task automatic test_w_sel();
	logic [15:0] ac_v;
	logic [15:0] at_v;
	logic [15:0] e;
	ac_v = 16'($urandom);
	load_w(ac_v, 1'b1, 1'b0, 1'b0);
	// AT takes F = A in logic mode
	at_v = 16'($urandom);
	l = at_v;
	alu_ctrl.s_hi = 4'b1111;
	alu_ctrl.s_lo = 4'b1111;
	reg_ctrl.as2 = 1'b1;
	tick();
	reg_ctrl = '0;
	ir.raw = 16'($urandom);
	kl = 16'($urandom);
	rdt = 16'($urandom);
	ki = 16'($urandom);
	l = 16'($urandom);
	for (int sel = 0; sel < 8; sel++) begin
		for (int bl = 0; bl < 8; bl++) begin
			bus_ctrl.w_sel = w_sel_t'(sel[2:0]);
			bus_ctrl.bwa = bl[0];
			bus_ctrl.bwb = bl[1];
			bus_ctrl.w_dt = bl[2];
			#5;
			e = w_model(sel, ir.raw, l, ac_v, at_v);
			if (bl[0]) e[7:0] = 8'h00;
			if (bl[1]) e[15:8] = 8'h00;
			check_val("w", w, e);
			check_val("ddt_n", ddt_n, bl[2] ? ~e : 16'hffff);
		end
	end
	bus_ctrl = '0;
	bus_ctrl.a_sel = 2'd3;
endtask

task automatic run_alu(input logic [15:0] a, input logic [15:0] b, input logic [3:0] s,
	input logic m, input logic cin, input logic [3:0] corr);
	logic [16:0] r;
	logic        s1;
	alu_ctrl.s_hi = s;
	alu_ctrl.s_lo = s;
	alu_ctrl.m = m;
	alu_ctrl.cin = cin;
	{alu_ctrl.am1, alu_ctrl.apb, alu_ctrl.amb, alu_ctrl.ap1} = corr;
	alu_ctrl.axy = 1'b0;
	#5;
	r = alu_model(a, b, s, m, cin);
	s1 = s1_model(a, b, cin, r[16], corr);
	check_val("f", f, r[15:0]);
	check_val("s0", 16'(flags.s0), 16'(r[15]));
	check_val("j", 16'(flags.j), 16'(r[15:0] == 16'hffff));
	check_val("exx", 16'(flags.exx), 16'(ir.fields.d ? a[0] : a[15]));
	check_val("exy", 16'(flags.exy), 16'(a[15]));
	if (m) begin
		check_val("carry", 16'(flags.carry), 16'(r[16]));
		check_val("s_1", 16'(flags.s_1), 16'(s1));
		check_val("zs", 16'(flags.zs), 16'((r[15:0] == 16'h0) && !s1));
	end
endtask

task automatic alu_case(input logic [15:0] a, input logic [15:0] b, input logic [3:0] s,
	input logic m, input logic cin, input logic [3:0] corr);
	load_w(b, 1'b1, 1'b0, 1'b0);
	l = a;
	run_alu(a, b, s, m, cin, corr);
	alu_ctrl = '0;
endtask

task automatic test_alu();
	logic [15:0] a;
	logic [15:0] b;
	logic [3:0]  fn [6];
	fn = '{4'b0000, 4'b1111, 4'b1001, 4'b0110, 4'b1011, 4'b1110};
	for (int n = 0; n < 8; n++) begin
		a = 16'($urandom);
		b = 16'($urandom);
		ir.fields.d = n[0];
		alu_case(a, b, 4'b1001, 1'b1, 1'b0, 4'b0000);
		run_alu(a, b, 4'b1001, 1'b1, 1'b1, 4'b0000);
		run_alu(a, b, 4'b0110, 1'b1, 1'b1, 4'b0000);
		for (int k = 0; k < 6; k++) begin
			run_alu(a, b, fn[k], 1'b0, 1'b0, 4'b0000);
		end
	end
	// zero, carry into the sign, overflow correction, all ones
	alu_case(16'h0000, 16'h0000, 4'b1001, 1'b1, 1'b0, 4'b0000);
	alu_case(16'hffff, 16'h0001, 4'b1001, 1'b1, 1'b0, 4'b0000);
	alu_case(16'hffff, 16'h0001, 4'b1001, 1'b1, 1'b0, 4'b0100);
	alu_case(16'h8000, 16'h8000, 4'b0110, 1'b1, 1'b1, 4'b0000);
	alu_case(16'h8000, 16'h8000, 4'b0110, 1'b1, 1'b1, 4'b0010);
	alu_case(16'h0000, 16'h1234, 4'b1111, 1'b1, 1'b0, 4'b1000);
	alu_case(16'hffff, 16'h1234, 4'b0000, 1'b1, 1'b1, 4'b0001);
	alu_case(16'hffff, 16'h1234, 4'b1111, 1'b0, 1'b0, 4'b0000);
	alu_case(16'hfffe, 16'h1234, 4'b1111, 1'b0, 1'b0, 4'b0000);
endtask

task automatic test_at_wzi();
	logic [15:0] at_v;
	logic        e0;
	load_w(16'h0000, 1'b1, 1'b0, 1'b0);
	alu_ctrl.s_hi = 4'b1001;
	alu_ctrl.s_lo = 4'b1001;
	alu_ctrl.m = 1'b1;
	l = 16'h0000;
	reg_ctrl.as2 = 1'b1;
	tick();
	bus_ctrl.w_sel = W_AT;
	#5;
	check_val("at", w, 16'h0);
	check_val("wzi", 16'(wzi), 16'h1);
	at_v = 16'($urandom) | 16'h0100;
	l = at_v;
	tick();
	reg_ctrl = '0;
	#5;
	check_val("at", w, at_v);
	check_val("wzi", 16'(wzi), 16'h0);
	// AT holds with as2 and wx low
	tick();
	#5;
	check_val("at", w, at_v);
	// F stays zero while shifting, so wzi only moves on as2
	l = 16'h0000;
	alu_ctrl.axy = 1'b1;
	reg_ctrl.wx = 1'b1;
	for (int n = 0; n < 6; n++) begin
		e0 = 1'($urandom);
		reg_ctrl.eat0 = e0;
		tick();
		at_v = {e0, at_v[15:1]};
		#5;
		check_val("at", w, at_v);
		check_val("at15", 16'(flags.at15), 16'(at_v[0]));
		check_val("exy", 16'(flags.exy), 16'(at_v[0]));
	end
	check_val("wzi", 16'(wzi), 16'h0);
	reg_ctrl = '0;
	alu_ctrl = '0;
endtask

task automatic test_ar_ic();
	logic [15:0] ar_v;
	logic [15:0] ic_v;
	ar_v = 16'($urandom) | 16'h0400;
	ic_v = 16'($urandom);
	load_w(ar_v, 1'b0, 1'b1, 1'b0);
	load_w(ic_v, 1'b0, 1'b0, 1'b1);
	read_ar_ic(ar_v, ic_v);
	reg_ctrl.arp1 = 1'b1;
	reg_ctrl.icp1 = 1'b1;
	tick();
	reg_ctrl = '0;
	read_ar_ic(ar_v + 16'd1, ic_v + 16'd1);
	reg_ctrl.arm4 = 1'b1;
	tick();
	reg_ctrl = '0;
	read_ar_ic(ar_v + 16'd1 - 16'(`PA_AR_M4), ic_v + 16'd1);
	// load wins over counting, clear wins over load
	ar_v = 16'h00a5;
	reg_ctrl.arp1 = 1'b1;
	reg_ctrl.off = 1'b1;
	load_w(ar_v, 1'b0, 1'b1, 1'b1);
	read_ar_ic(ar_v, 16'h0);
	reg_ctrl.icp1 = 1'b1;
	load_w(16'h7f3c, 1'b0, 1'b0, 1'b1);
	read_ar_ic(ar_v, 16'h7f3c);
endtask

task automatic test_zga();
	logic [15:0] ar_v;
	logic [15:0] addr;
	logic        hit;
	for (int n = 0; n < 10; n++) begin
		ar_v = 16'($urandom);
		load_w(ar_v, 1'b0, 1'b1, 1'b0);
		bus_ctrl.w_sel = W_A;
		bus_ctrl.ar_ad = 1'b1;
		bus_ctrl.barnb = 1'($urandom);
		addr = {bus_ctrl.barnb, ~ar_v[14:0]};
		hit = n[0];
		kl = hit ? addr : addr ^ (16'($urandom) | 16'h0010);
		#5;
		check_val("zga", 16'(zga), 16'(hit));
		bus_ctrl.ar_ad = 1'b0;
	end
endtask

`endif

// File: tb_pa_unit.sv
`timescale 1ns/10ps
`include "pa_macros.svh"

module tb_pa_unit
	import pa_pkg::*;
;

	logic        clk;
	logic        rst_n;
	ir_word_u    ir;
	logic [15:0] ki;
	logic [15:0] kl;
	logic [15:0] rdt;
	logic [15:0] l;
	alu_ctrl_t   alu_ctrl;
	reg_ctrl_t   reg_ctrl;
	bus_ctrl_t   bus_ctrl;
	logic [15:0] ddt_n;
	logic [15:0] dad_n;
	logic [15:0] w;
	logic [15:0] f;
	flag_t       flags;
	logic        wzi;
	logic        zga;
	logic        arz;
	int          err_count;
	int          check_count;

	pa_unit dut0 (
		.clk      (clk),
		.rst_n    (rst_n),
		.ir       (ir),
		.ki       (ki),
		.kl       (kl),
		.rdt      (rdt),
		.l        (l),
		.alu_ctrl (alu_ctrl),
		.reg_ctrl (reg_ctrl),
		.bus_ctrl (bus_ctrl),
		.ddt_n    (ddt_n),
		.dad_n    (dad_n),
		.w        (w),
		.f        (f),
		.flags    (flags),
		.wzi      (wzi),
		.zga      (zga),
		.arz      (arz)
	);

	// 74181 function table, active high data, b is AC
	function automatic logic [16:0] alu_model(input logic [15:0] a, input logic [15:0] b,
		input logic [3:0] s, input logic m, input logic cin);
		logic [16:0] r;
		r = '0;
		if (m) begin
			case (s)
				4'b1001: r = {1'b0, a} + {1'b0, b} + {16'h0, cin};
				4'b0110: r = {1'b0, a} + {1'b0, ~b} + {16'h0, cin};
				// a minus one
				4'b1111: r = {1'b0, a} + 17'h0ffff + {16'h0, cin};
				4'b0000: r = {1'b0, a} + {16'h0, cin};
				default: r = '0;
			endcase
		end else begin
			case (s)
				4'b0000: r = {1'b0, ~a};
				4'b1111: r = {1'b0, a};
				4'b1001: r = {1'b0, ~(a ^ b)};
				4'b0110: r = {1'b0, a ^ b};
				4'b1011: r = {1'b0, a & b};
				4'b1110: r = {1'b0, a | b};
				default: r = '0;
			endcase
		end
		return r;
	endfunction

	// sign of the exact 17-bit result, corr is {am1, apb, amb, ap1}
	// without a correction the flag is the plain carry
	function automatic logic s1_model(input logic [15:0] a, input logic [15:0] b,
		input logic cin, input logic carry, input logic [3:0] corr);
		logic [16:0] ax;
		logic [16:0] e;
		ax = {a[15], a};
		case (corr)
			4'b1000: e = ax + 17'h1ffff + {16'h0, cin};
			4'b0100: e = ax + {b[15], b} + {16'h0, cin};
			4'b0010: e = ax + {~b[15], ~b} + {16'h0, cin};
			4'b0001: e = ax + {16'h0, cin};
			default: e = {carry, 16'h0};
		endcase
		return e[16];
	endfunction

	function automatic logic [15:0] w_model(input int sel, input logic [15:0] irw,
		input logic [15:0] a, input logic [15:0] ac, input logic [15:0] at);
		case (sel)
			0: return irw;
			1: return kl;
			2: return rdt;
			3: return {8'h00, ac[15:8]};
			4: return ki;
			5: return at;
			6: return ac;
			default: return a;
		endcase
	endfunction

	`include "tb_pa_tasks.svh"

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// overall limit on the run
	initial begin
		#2000000;
		$display("simulation did not finish in time");
		$display("Some tests failed");
		$finish;
	end

	initial begin
		err_count = 0;
		check_count = 0;
		void'($urandom(32'hb285));
		rst_n = 1'b0;
		set_idle();
		repeat (3) tick();
		rst_n = 1'b1;
		test_reset();
		test_w_sel();
		test_alu();
		test_at_wzi();
		test_ar_ic();
		test_zga();
		$display("checks %0d, errors %0d", check_count, err_count);
		if (err_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// File: pa_unit.sv
`timescale 1ns/10ps
`include "pa_macros.svh"

module pa_unit
	import pa_pkg::*;
(
	input  logic             clk,
	input  logic             rst_n,
	input  ir_word_u         ir,
	input  logic [0:`PA_W-1] ki,
	input  logic [0:`PA_W-1] kl,
	input  logic [0:`PA_W-1] rdt,
	input  logic [0:`PA_W-1] l,
	input  alu_ctrl_t        alu_ctrl,
	input  reg_ctrl_t        reg_ctrl,
	input  bus_ctrl_t        bus_ctrl,
	output logic [0:`PA_W-1] ddt_n,
	output logic [0:`PA_W-1] dad_n,
	output logic [0:`PA_W-1] w,
	output logic [0:`PA_W-1] f,
	output flag_t            flags,
	output logic             wzi,
	output logic             zga,
	output logic             arz
);

	logic [0:`PA_W-1] a_bus;
	logic [0:`PA_W-1] at;
	logic [0:`PA_W-1] ac;
	logic [0:`PA_W-1] ar;
	logic [0:`PA_W-1] ic;

	pa_bus u_bus (
		.ir    (ir),
		.ki    (ki),
		.kl    (kl),
		.rdt   (rdt),
		.l     (l),
		.at    (at),
		.ac    (ac),
		.ar    (ar),
		.ic    (ic),
		.ctrl  (bus_ctrl),
		.w     (w),
		.a     (a_bus),
		.ddt_n (ddt_n),
		.dad_n (dad_n),
		.zga   (zga)
	);

	// arithmetic path, A against AC
	pa_arith u_arith (
		.clk      (clk),
		.rst_n    (rst_n),
		.a        (a_bus),
		.ac       (ac),
		.ir       (ir),
		.ctrl     (alu_ctrl),
		.reg_ctrl (reg_ctrl),
		.f        (f),
		.at       (at),
		.flags    (flags),
		.wzi      (wzi)
	);

	pa_regs u_regs (
		.clk   (clk),
		.rst_n (rst_n),
		.w     (w),
		.ctrl  (reg_ctrl),
		.ac    (ac),
		.ar    (ar),
		.ic    (ic),
		.arz   (arz)
	);

endmodule

// File: pa_bus.sv
`timescale 1ns/10ps
`include "pa_macros.svh"

module pa_bus
	import pa_pkg::*;
(
	input  ir_word_u         ir,
	input  logic [0:`PA_W-1] ki,
	input  logic [0:`PA_W-1] kl,
	input  logic [0:`PA_W-1] rdt,
	input  logic [0:`PA_W-1] l,
	input  logic [0:`PA_W-1] at,
	input  logic [0:`PA_W-1] ac,
	input  logic [0:`PA_W-1] ar,
	input  logic [0:`PA_W-1] ic,
	input  bus_ctrl_t        ctrl,
	output logic [0:`PA_W-1] w,
	output logic [0:`PA_W-1] a,
	output logic [0:`PA_W-1] ddt_n,
	output logic [0:`PA_W-1] dad_n,
	output logic             zga
);

	localparam int HB = `PA_W / 2;

	logic [0:`PA_W-1] a_src;
	logic [0:`PA_W-1] w_src;

	// A selector, code 0 is the short argument form
	always_comb begin
		case (ctrl.a_sel)
			2'd0: a_src = {l[HB:`PA_W-1], ir.fields.ra.tb, ir.fields.t};
			2'd1: a_src = ic;
			2'd2: a_src = ar;
			default: a_src = l;
		endcase
	end

	// blanks on bits 0:7, 8:9 and 10:15
	assign a[0:HB-1] = ctrl.bac ? '0 : a_src[0:HB-1];
	assign a[HB:HB+1] = ctrl.bab ? '0 : a_src[HB:HB+1];
	assign a[HB+2:`PA_W-1] = ctrl.baa ? '0 : a_src[HB+2:`PA_W-1];

	always_comb begin
		case (ctrl.w_sel)
			W_IR:          w_src = ir.raw;
			W_KL:          w_src = kl;
			W_RDT:         w_src = rdt;
			// ac high byte moves down, upper half stays zero
			W_AC_LOW_SWAP: w_src = {{HB{1'b0}}, ac[0:HB-1]};
			W_KI:          w_src = ki;
			W_AT:          w_src = at;
			W_AC:          w_src = ac;
			default:       w_src = a;
		endcase
	end

	// bwb blanks the high byte, bwa the low byte
	assign w[0:HB-1] = ctrl.bwb ? '0 : w_src[0:HB-1];
	assign w[HB:`PA_W-1] = ctrl.bwa ? '0 : w_src[HB:`PA_W-1];

	// open collector drivers, idle bus reads all ones
	assign ddt_n = ~(w & {`PA_W{ctrl.w_dt}});
	assign dad_n = ~(ar & {`PA_W{ctrl.ar_ad}}) & ~(ic & {`PA_W{ctrl.ic_ad}});

	// keys against address, block bit takes the place of bit 0
	assign zga = (kl == {ctrl.barnb, dad_n[1:`PA_W-1]});

endmodule

// File: pa_regs.sv
`timescale 1ns/10ps
`include "pa_macros.svh"

module pa_regs
	import pa_pkg::*;
(
	input  logic             clk,
	input  logic             rst_n,
	input  logic [0:`PA_W-1] w,
	input  reg_ctrl_t        ctrl,
	output logic [0:`PA_W-1] ac,
	output logic [0:`PA_W-1] ar,
	output logic [0:`PA_W-1] ic,
	output logic             arz
);

	// accumulator, loads from W only
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ac <= '0;
		end else if (ctrl.w_ac) begin
			ac <= w;
		end
	end

	// argument register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ar <= '0;
		end else if (ctrl.w_ar) begin
			ar <= w;
		end else if (ctrl.arp1) begin
			ar <= ar + `PA_W'(1);
		end else if (ctrl.arm4) begin
			ar <= ar - `PA_W'(`PA_AR_M4);
		end
	end

	// instruction counter, off wins over everything
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ic <= `PA_IC_RST;
		end else if (ctrl.off) begin
			ic <= '0;
		end else if (ctrl.w_ic) begin
			ic <= w;
		end else if (ctrl.icp1) begin
			ic <= ic + `PA_W'(1);
		end
	end

	// upper byte of AR in use
	assign arz = |ar[0:`PA_W/2-1];

endmodule

// File: pa_arith.sv
`timescale 1ns/10ps
`include "pa_macros.svh"

module pa_arith
	import pa_pkg::*;
(
	input  logic             clk,
	input  logic             rst_n,
	input  logic [0:`PA_W-1] a,
	input  logic [0:`PA_W-1] ac,
	input  ir_word_u         ir,
	input  alu_ctrl_t        ctrl,
	input  reg_ctrl_t        reg_ctrl,
	output logic [0:`PA_W-1] f,
	output logic [0:`PA_W-1] at,
	output flag_t            flags,
	output logic             wzi
);

	logic [0:3] p;
	logic [0:3] g;
	logic [0:3] eq;
	logic [0:3] ci;
	logic [0:3] co;
	logic       sign_sel;
	logic       s_1;
	logic       zs;

	// slice 0 holds the most significant nibble
	genvar i;
	generate
		for (i = 0; i < 4; i++) begin : g_slice
			pa_alu_slice u_slice (
				.a    (a[i*`PA_SLICE +: `PA_SLICE]),
				.b    (ac[i*`PA_SLICE +: `PA_SLICE]),
				.s    ((i < 2) ? ctrl.s_hi : ctrl.s_lo),
				.m    (ctrl.m),
				.cin  (ci[i]),
				.f    (f[i*`PA_SLICE +: `PA_SLICE]),
				.p    (p[i]),
				.g    (g[i]),
				.eq   (eq[i]),
				.cout (co[i])
			);
		end
	endgenerate

	// 74182 lookahead, carry enters at the least significant slice
	assign ci[3] = ctrl.cin;
	assign ci[2] = g[3] | (p[3] & ctrl.cin);
	assign ci[1] = g[2] | (p[2] & g[3]) | (p[2] & p[3] & ctrl.cin);
	assign ci[0] = g[1] | (p[1] & g[2]) | (p[1] & p[2] & g[3])
		| (p[1] & p[2] & p[3] & ctrl.cin);

	// sign correction for overflow
	assign sign_sel = (~a[0] & ctrl.am1)
		| ((ac[0] ^ a[0]) & ctrl.apb)
		| (~(ac[0] ^ a[0]) & ctrl.amb)
		| (a[0] & ctrl.ap1);
	assign s_1 = sign_sel ^ co[0];

	assign zs = (f == '0) & ~s_1;

	assign flags.carry = co[0];
	assign flags.s0 = f[0];
	assign flags.s_1 = s_1;
	assign flags.zs = zs;
	assign flags.j = &eq;
	assign flags.exx = ir.fields.d ? a[`PA_W-1] : a[0];
	assign flags.exy = ctrl.axy ? at[`PA_W-1] : a[0];
	assign flags.at15 = at[`PA_W-1];

	// AT works like a 74194: load on as2, else shift towards bit 15
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			at <= '0;
		end else if (reg_ctrl.as2) begin
			at <= f;
		end else if (reg_ctrl.wx) begin
			at <= {reg_ctrl.eat0, at[0:`PA_W-2]};
		end
	end

	// zero flag as seen while AT is loaded
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wzi <= 1'b0;
		end else if (reg_ctrl.as2) begin
			wzi <= zs;
		end
	end

endmodule

// File: pa_alu_slice.sv
`timescale 1ns/10ps
`include "pa_macros.svh"

module pa_alu_slice (
	input  logic [0:`PA_SLICE-1] a,
	input  logic [0:`PA_SLICE-1] b,
	input  logic [3:0]           s,
	input  logic                 m,
	input  logic                 cin,
	output logic [0:`PA_SLICE-1] f,
	output logic                 p,
	output logic                 g,
	output logic                 eq,
	output logic                 cout
);

	logic [0:`PA_SLICE-1] x;
	logic [0:`PA_SLICE-1] y;
	logic [0:`PA_SLICE-1] h;
	logic [`PA_SLICE:0]   sum;
	logic [`PA_SLICE:0]   sum_nc;

	// the two operand terms of the 74181, arithmetic result is x plus y
	assign x = a | (b & {`PA_SLICE{s[0]}}) | (~b & {`PA_SLICE{s[1]}});
	assign y = (a & ~b & {`PA_SLICE{s[2]}}) | (a & b & {`PA_SLICE{s[3]}});

	// y is always a subset of x, so x alone decides propagation
	assign h = x ^ y;

	assign sum = {1'b0, x} + {1'b0, y} + {{`PA_SLICE{1'b0}}, cin};
	assign sum_nc = {1'b0, x} + {1'b0, y};

	// logic mode gives the inverted half sum
	assign f = m ? sum[`PA_SLICE-1:0] : ~h;

	// group signals for the lookahead unit
	assign g = sum_nc[`PA_SLICE];
	assign p = &x;
	assign cout = g | (p & cin);

	// open collector A=B output in the original part
	assign eq = &f;

endmodule

// File: pa_pkg.sv
`include "pa_macros.svh"

package pa_pkg;

	// W bus sources, in select code order
	typedef enum logic [2:0] {
		W_IR          = 3'd0,
		W_KL          = 3'd1,
		W_RDT         = 3'd2,
		W_AC_LOW_SWAP = 3'd3,
		W_KI          = 3'd4,
		W_AT          = 3'd5,
		W_AC          = 3'd6,
		W_A           = 3'd7
	} w_sel_t;

	// register field of the instruction, low two bits double as tb
	typedef struct packed {
		logic       hi;
		logic [0:1] tb;
	} ra_t;

	typedef struct packed {
		logic [0:5] op;
		logic       d;
		ra_t        ra;
		logic [0:5] t;
	} ir_fields_t;

	// instruction word, seen either as a plain word or by its fields
	typedef union packed {
		logic [0:`PA_W-1] raw;
		ir_fields_t       fields;
	} ir_word_u;

	typedef struct packed {
		logic [3:0] s_hi;
		logic [3:0] s_lo;
		logic       m;
		logic       cin;
		// sign correction selects
		logic       am1;
		logic       apb;
		logic       amb;
		logic       ap1;
		logic       axy;
	} alu_ctrl_t;

	typedef struct packed {
		logic w_ac;
		logic w_ar;
		logic w_ic;
		logic arp1;
		logic arm4;
		logic icp1;
		logic as2;
		logic wx;
		logic eat0;
		logic off;
	} reg_ctrl_t;

	typedef struct packed {
		w_sel_t     w_sel;
		logic       bwa;
		logic       bwb;
		logic [1:0] a_sel;
		logic       bac;
		logic       bab;
		logic       baa;
		logic       w_dt;
		logic       ic_ad;
		logic       ar_ad;
		logic       barnb;
	} bus_ctrl_t;

	typedef struct packed {
		logic carry;
		logic s0;
		logic s_1;
		logic zs;
		logic j;
		logic exx;
		logic exy;
		logic at15;
	} flag_t;

endpackage

// File: pa_macros.svh
`ifndef PA_MACROS_SVH
`define PA_MACROS_SVH

// data path word width, bit 0 is the msb
`define PA_W 16

// width of one 74181-style slice
`define PA_SLICE 4

// instruction counter value after reset
`define PA_IC_RST 16'h0000

// step-back amount of the AR register
`define PA_AR_M4 4

`endif
